//--- Bender.yml
package:
  name: pll_reconf

sources:
  - files:
      - pll_reconf_pkg.sv
      - pll_reconf_uif_regs.sv
      - pll_reconf_l2p_table.sv
      - pll_reconf_rmw_merge.sv
      - pll_reconf_seq.sv
      - pll_reconf_top.sv
  - target: test
    files:
      - tb_pll_reconf_props.sv
      - tb_pll_reconf.sv

//--- pll_reconf.f
pll_reconf_pkg.sv
pll_reconf_uif_regs.sv
pll_reconf_l2p_table.sv
pll_reconf_rmw_merge.sv
pll_reconf_seq.sv
pll_reconf_top.sv
tb_pll_reconf_props.sv
tb_pll_reconf.sv

//--- pll_reconf_l2p_table.sv
// Physical refclk and CGB tables loaded from basic-block ROM reads
// Logical indices above 4 select entry 0
`timescale 1ns/100ps
`default_nettype none

module pll_reconf_l2p_table
  import pll_reconf_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                rom_capture,
  input  switch_type_e                        switch_type,
  input  logic [CTRL_DATA_W-1:0]              ctrl_rdata,
  input  logic [LOGICAL_IDX_W-1:0]            logical_idx,
  output logic [L2P_ENTRIES*REFCLK_ID_W-1:0]  phys_refclk,
  output logic [L2P_ENTRIES*CGB_ID_W-1:0]     phys_cgb,
  output logic [REFCLK_ID_W-1:0]              refclk_id,
  output logic [CGB_ID_W-1:0]                 cgb_id
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phys_refclk <= '0;
      phys_cgb    <= '0;
    end else if (rom_capture) begin
      if (switch_type == SW_CGB)
        phys_cgb <= ctrl_rdata[L2P_ENTRIES*CGB_ID_W-1:0];       // Five 4-bit ids
      else
        phys_refclk <= ctrl_rdata[L2P_ENTRIES*REFCLK_ID_W-1:0]; // Five 5-bit ids
    end
  end

  always_comb begin
    refclk_id = phys_refclk[REFCLK_ID_W-1:0];
    cgb_id    = phys_cgb[CGB_ID_W-1:0];
    if (logical_idx < L2P_ENTRIES) begin
      refclk_id = phys_refclk[logical_idx*REFCLK_ID_W +: REFCLK_ID_W];
      cgb_id    = phys_cgb[logical_idx*CGB_ID_W +: CGB_ID_W];
    end
  end

endmodule

`default_nettype wire

//--- pll_reconf_pkg.sv
// Shared widths, DPRIO offsets and encodings for the PLL reconfiguration controller
// Physical tables hold five entries, so logical indices above 4 fall back to entry 0
`default_nettype none

package pll_reconf_pkg;

  localparam int UIF_ADDR_W    = 3;
  localparam int UIF_DATA_W    = 32;
  localparam int CTRL_ADDR_W   = 12;
  localparam int CTRL_DATA_W   = 32;
  localparam int LCH_W         = 10;
  localparam int DPRIO_W       = 16;
  localparam int REFCLK_ID_W   = 5;
  localparam int CGB_ID_W      = 4;
  localparam int L2P_ENTRIES   = 5;
  localparam int LOGICAL_IDX_W = 3;

  // ROM word selects for the logical-to-physical tables
  localparam logic [CTRL_ADDR_W-1:0] ROM_SEL_REFCLK = 12'd1;
  localparam logic [CTRL_ADDR_W-1:0] ROM_SEL_CGB    = 12'd2;

  localparam logic [CTRL_ADDR_W-1:0] OFST_REFIQ       = 12'h03A; // Refclk primary
  localparam logic [CTRL_ADDR_W-1:0] OFST_PCIEMD_RREF = 12'h017; // Refclk secondary
  localparam logic [CTRL_ADDR_W-1:0] OFST_CGB         = 12'h020; // CGB primary
  localparam logic [CTRL_ADDR_W-1:0] OFST_CLKNET      = 12'h021; // CGB secondary

  typedef enum logic [2:0] {
    UIF_RD   = 3'd0,
    UIF_WR   = 3'd1,
    UIF_PHYS = 3'd2
  } uif_mode_e;

  typedef enum logic [2:0] {
    OP_RD     = 3'd0,
    OP_WR     = 3'd1,
    OP_PHYS   = 3'd2,
    OP_INT_WR = 3'd3,
    OP_ROM_RD = 3'd4
  } ctrl_op_e;

  typedef enum logic {
    SW_REFCLK = 1'b0,
    SW_CGB    = 1'b1
  } switch_type_e;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_RD_L2P    = 3'd1, // ROM read of the physical table
    ST_RD        = 3'd2, // DPRIO read
    ST_WR        = 3'd3, // DPRIO write
    ST_WAIT      = 3'd4, // Lets ctrl_wait rise
    ST_DECIDE    = 3'd5,
    ST_CHK_WORDS = 3'd6
  } pll_state_e;

endpackage

`default_nettype wire

//--- pll_reconf_rmw_merge.sv
// DPRIO read-modify-write merge for refclk and CGB switches
// Unknown physical ids fall back to REF_IQCLK0 or the local CGB clock
`timescale 1ns/100ps
`default_nettype none

module pll_reconf_rmw_merge
  import pll_reconf_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dprio_capture,
  input  logic [CTRL_DATA_W-1:0] ctrl_rdata,
  input  switch_type_e           switch_type,
  input  logic                   word_sel,
  input  logic [REFCLK_ID_W-1:0] refclk_id,
  input  logic [CGB_ID_W-1:0]    cgb_id,
  output logic [DPRIO_W-1:0]     merged_word
);

  logic [DPRIO_W-1:0]     saved_word;
  logic [REFCLK_ID_W-1:0] rx_num;
  logic [7:0]             iq_sel;
  logic                   rrefclk_sel;
  logic [1:0]             x_en;
  logic                   clknet_in_en;
  logic [5:0]             clk_sel;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      saved_word <= '0;
    else if (dprio_capture)
      saved_word <= ctrl_rdata[DPRIO_W-1:0];
  end

  assign rx_num = refclk_id - 5'd10; // RX_IQCLK number plus one

  always_comb begin
    iq_sel      = 8'h01;
    rrefclk_sel = 1'b0;
    if (refclk_id <= 5'd10)
      iq_sel = 8'(refclk_id) + 8'd1;   // REF_IQCLK
    else if (refclk_id <= 5'd21)
      iq_sel = {rx_num[3:0], 4'h0};    // RX_IQCLK in the high nibble
    else if (refclk_id == 5'd22) begin
      iq_sel      = 8'h00;
      rrefclk_sel = 1'b1;              // PLD clock
    end else if (refclk_id == 5'd23 || refclk_id == 5'd25)
      iq_sel = 8'h00;
    else if (refclk_id == 5'd24)
      iq_sel = 8'h0C;
  end

  always_comb begin
    case (cgb_id)
      4'd0:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h2C}; // Same channel TX PLL
      4'd1:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h13};
      4'd2:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h20};
      4'd3:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h12};
      4'd4:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h10};
      4'd5:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h11};
      4'd6:    {x_en, clknet_in_en, clk_sel} = {2'd2, 1'b1, 6'h28}; // x6 up
      4'd7:    {x_en, clknet_in_en, clk_sel} = {2'd1, 1'b1, 6'h24}; // x6 down
      4'd8:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b1, 6'h24};
      4'd9:    {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b1, 6'h28};
      default: {x_en, clknet_in_en, clk_sel} = {2'd0, 1'b0, 6'h2C};
    endcase
  end

  // word_sel high picks the secondary word
  always_comb begin
    if (switch_type == SW_CGB) begin
      if (word_sel)
        merged_word = {saved_word[15:10], clknet_in_en, saved_word[8:0]};
      else
        merged_word = {saved_word[15:13], x_en, saved_word[10:6], clk_sel};
    end else begin
      if (word_sel)
        merged_word = {rrefclk_sel, 1'b0, saved_word[13:0]}; // PCIe mode never set
      else
        merged_word = {saved_word[15:11], iq_sel, saved_word[2:0]};
    end
  end

endmodule

`default_nettype wire

//--- pll_reconf_seq.sv
// Switch and lookup sequencer driving the basic-block control port
// A switch is one ROM read then read-modify-write of the secondary and primary words
`timescale 1ns/100ps
`default_nettype none

module pll_reconf_seq
  import pll_reconf_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   switch_go,
  input  logic                   lookup_go,
  input  switch_type_e           switch_type,
  input  logic [DPRIO_W-1:0]     merged_word,
  input  logic                   ctrl_wait,
  output logic                   uif_busy,
  output logic                   ctrl_go,
  output ctrl_op_e               ctrl_opcode,
  output logic                   ctrl_lock,
  output logic [CTRL_ADDR_W-1:0] ctrl_addr,
  output logic [CTRL_DATA_W-1:0] ctrl_wdata,
  output logic                   rom_capture,
  output logic                   dprio_capture,
  output logic                   lookup_done,
  output logic                   word_sel
);

  pll_state_e state;
  pll_state_e next_state;
  logic [1:0] event_cnt;  // Completed control cycles in this word
  logic       word_cnt;   // 1 while on the secondary word
  logic       is_lookup;

  assign word_sel      = word_cnt;
  assign rom_capture   = (state == ST_DECIDE) && !ctrl_wait && (ctrl_opcode == OP_ROM_RD);
  assign dprio_capture = (state == ST_DECIDE) && !ctrl_wait && (ctrl_opcode == OP_RD);

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE:
        if (switch_go || lookup_go)
          next_state = ST_RD_L2P;
      ST_RD_L2P, ST_RD, ST_WR:
        next_state = ST_WAIT;
      ST_WAIT:
        next_state = ST_DECIDE;
      ST_DECIDE:
        if (!ctrl_wait) begin
          if (is_lookup)
            next_state = ST_IDLE;
          else begin
            case (event_cnt)
              2'd1:    next_state = ST_RD;
              2'd2:    next_state = ST_WR;
              2'd3:    next_state = ST_CHK_WORDS;
              default: next_state = ST_IDLE;
            endcase
          end
        end
      ST_CHK_WORDS:
        next_state = word_cnt ? ST_WAIT : ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ST_IDLE;
      event_cnt   <= 2'd0;
      word_cnt    <= 1'b0;
      is_lookup   <= 1'b0;
      lookup_done <= 1'b0;
    end else begin
      state       <= next_state;
      lookup_done <= (state == ST_DECIDE) && (next_state == ST_IDLE);

      if (state == ST_IDLE || next_state == ST_CHK_WORDS)
        event_cnt <= 2'd0;
      else if (state == ST_WAIT)
        event_cnt <= event_cnt + 2'd1;

      if (state == ST_RD_L2P)
        word_cnt <= 1'b1;  // Two words per switch
      else if (state == ST_CHK_WORDS && word_cnt)
        word_cnt <= 1'b0;

      if (state == ST_IDLE)
        is_lookup <= lookup_go;
    end
  end

  // Registered control port, each pulse follows its issuing state
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_busy    <= 1'b0;
      ctrl_go     <= 1'b0;
      ctrl_opcode <= OP_RD;
      ctrl_lock   <= 1'b0;
      ctrl_addr   <= '0;
      ctrl_wdata  <= '0;
    end else begin
      uif_busy <= (next_state != ST_IDLE);
      ctrl_go  <= (state == ST_RD_L2P) || (state == ST_RD) || (state == ST_WR);

      if (next_state == ST_IDLE)
        ctrl_opcode <= OP_RD;
      else if (state == ST_RD_L2P)
        ctrl_opcode <= OP_ROM_RD;
      else if (state == ST_RD)
        ctrl_opcode <= OP_RD;
      else if (state == ST_WR)
        ctrl_opcode <= OP_WR;

      if (state == ST_RD_L2P)
        ctrl_lock <= !is_lookup;
      else if (state == ST_IDLE || (state == ST_WR && !word_cnt))
        ctrl_lock <= 1'b0;  // Released with the final write

      if (state == ST_IDLE)
        ctrl_addr <= '0;
      else if (state == ST_RD_L2P)
        ctrl_addr <= (switch_type == SW_CGB) ? ROM_SEL_CGB : ROM_SEL_REFCLK;
      else if (state == ST_RD || state == ST_WR) begin
        if (switch_type == SW_CGB)
          ctrl_addr <= word_cnt ? OFST_CLKNET : OFST_CGB;
        else
          ctrl_addr <= word_cnt ? OFST_PCIEMD_RREF : OFST_REFIQ;
      end

      if (state == ST_IDLE)
        ctrl_wdata <= '0;
      else if (state == ST_WR)
        ctrl_wdata <= CTRL_DATA_W'(merged_word);
    end
  end

endmodule

`default_nettype wire

//--- pll_reconf_top.sv
// PLL clock-source reconfiguration controller for one transceiver channel
// Do not pulse uif_go while uif_busy is high; ctrl_lch follows uif_lch directly
`timescale 1ns/100ps
`default_nettype none

module pll_reconf_top
  import pll_reconf_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   uif_go,
  input  uif_mode_e              uif_mode,
  output logic                   uif_busy,
  input  logic [UIF_ADDR_W-1:0]  uif_addr,
  input  logic [UIF_DATA_W-1:0]  uif_wdata,
  output logic [UIF_DATA_W-1:0]  uif_rdata,
  output logic                   uif_addr_err,
  input  logic [LCH_W-1:0]       uif_lch,
  output logic                   ctrl_go,
  output ctrl_op_e               ctrl_opcode,
  output logic                   ctrl_lock,
  input  logic                   ctrl_wait,
  output logic [LCH_W-1:0]       ctrl_lch,
  output logic [CTRL_ADDR_W-1:0] ctrl_addr,
  input  logic [CTRL_DATA_W-1:0] ctrl_rdata,
  output logic [CTRL_DATA_W-1:0] ctrl_wdata
);

  logic                               switch_go;
  logic                               lookup_go;
  logic                               lookup_done;
  switch_type_e                       switch_type;
  logic [LOGICAL_IDX_W-1:0]           logical_idx;
  logic                               rom_capture;
  logic                               dprio_capture;
  logic                               word_sel;
  logic [L2P_ENTRIES*REFCLK_ID_W-1:0] phys_refclk;
  logic [L2P_ENTRIES*CGB_ID_W-1:0]    phys_cgb;
  logic [REFCLK_ID_W-1:0]             refclk_id;
  logic [CGB_ID_W-1:0]                cgb_id;
  logic [DPRIO_W-1:0]                 merged_word;

  assign ctrl_lch = uif_lch;

  pll_reconf_uif_regs i_regs (
    .clk, .reset, .uif_go, .uif_mode, .uif_addr, .uif_wdata, .lookup_done,
    .phys_refclk, .phys_cgb, .uif_rdata, .uif_addr_err, .switch_go, .lookup_go,
    .switch_type, .logical_idx
  );

  pll_reconf_l2p_table i_table (
    .clk, .reset, .rom_capture, .switch_type, .ctrl_rdata, .logical_idx,
    .phys_refclk, .phys_cgb, .refclk_id, .cgb_id
  );

  pll_reconf_rmw_merge i_merge (
    .clk, .reset, .dprio_capture, .ctrl_rdata, .switch_type, .word_sel,
    .refclk_id, .cgb_id, .merged_word
  );

  pll_reconf_seq i_seq (
    .clk, .reset, .switch_go, .lookup_go, .switch_type, .merged_word, .ctrl_wait,
    .uif_busy, .ctrl_go, .ctrl_opcode, .ctrl_lock, .ctrl_addr, .ctrl_wdata,
    .rom_capture, .dprio_capture, .lookup_done, .word_sel
  );

endmodule

`default_nettype wire

//--- pll_reconf_uif_regs.sv
// User register port: offset 0 refclk index, 1 CGB index, 2 and 3 physical table lookups
// Lookup readback is refreshed in the cycle after uif_busy falls
`timescale 1ns/100ps
`default_nettype none

module pll_reconf_uif_regs
  import pll_reconf_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                uif_go,
  input  uif_mode_e                           uif_mode,
  input  logic [UIF_ADDR_W-1:0]               uif_addr,
  input  logic [UIF_DATA_W-1:0]               uif_wdata,
  input  logic                                lookup_done,
  input  logic [L2P_ENTRIES*REFCLK_ID_W-1:0]  phys_refclk,
  input  logic [L2P_ENTRIES*CGB_ID_W-1:0]     phys_cgb,
  output logic [UIF_DATA_W-1:0]               uif_rdata,
  output logic                                uif_addr_err,
  output logic                                switch_go,
  output logic                                lookup_go,
  output switch_type_e                        switch_type,
  output logic [LOGICAL_IDX_W-1:0]            logical_idx
);

  logic                     rc_sel_wr;
  logic                     cgb_sel_wr;
  logic                     rc_lookup;
  logic                     cgb_lookup;
  logic                     lookup_active;
  logic [LOGICAL_IDX_W-1:0] refclk_idx;
  logic [LOGICAL_IDX_W-1:0] cgb_idx;
  logic [UIF_DATA_W-1:0]    refclk_word;
  logic [UIF_DATA_W-1:0]    cgb_word;
  logic [UIF_DATA_W-1:0]    rd_word;

  assign rc_sel_wr  = uif_go && (uif_mode == UIF_WR) && (uif_addr == 3'd0);
  assign cgb_sel_wr = uif_go && (uif_mode == UIF_WR) && (uif_addr == 3'd1);
  assign rc_lookup  = uif_go && (uif_mode == UIF_RD) && (uif_addr == 3'd2);
  assign cgb_lookup = uif_go && (uif_mode == UIF_RD) && (uif_addr == 3'd3);

  assign lookup_go   = rc_lookup || cgb_lookup;
  assign logical_idx = (switch_type == SW_CGB) ? cgb_idx : refclk_idx;

  assign refclk_word = UIF_DATA_W'(phys_refclk);
  assign cgb_word    = UIF_DATA_W'(phys_cgb);

  always_comb begin
    case (uif_addr)
      3'd0:    rd_word = UIF_DATA_W'(refclk_idx);
      3'd1:    rd_word = UIF_DATA_W'(cgb_idx);
      3'd2:    rd_word = refclk_word;
      3'd3:    rd_word = cgb_word;
      default: rd_word = '0; // Out of range
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      refclk_idx    <= '0;
      cgb_idx       <= '0;
      switch_type   <= SW_REFCLK;
      switch_go     <= 1'b0;
      lookup_active <= 1'b0;
      uif_rdata     <= '0;
      uif_addr_err  <= 1'b0;
    end else begin
      switch_go <= rc_sel_wr || cgb_sel_wr; // Indices are current one cycle later
      if (rc_sel_wr)
        refclk_idx <= uif_wdata[LOGICAL_IDX_W-1:0];
      if (cgb_sel_wr)
        cgb_idx <= uif_wdata[LOGICAL_IDX_W-1:0];
      if (rc_sel_wr || rc_lookup)
        switch_type <= SW_REFCLK;
      else if (cgb_sel_wr || cgb_lookup)
        switch_type <= SW_CGB;

      if (lookup_done)
        lookup_active <= 1'b0;
      else if (lookup_go)
        lookup_active <= 1'b1;

      if (uif_go && (uif_mode == UIF_RD)) begin
        uif_rdata    <= rd_word;
        uif_addr_err <= (uif_addr > 3'd3);
      end else if (lookup_done && lookup_active) begin
        // Table now holds the fresh ROM word
        uif_rdata <= (switch_type == SW_CGB) ? cgb_word : refclk_word;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_pll_reconf.sv
// Table-driven testbench for pll_reconf_top with a basic-block model on the control port
// The model holds ctrl_wait 2 cycles per request and keeps a 4K x 16 DPRIO array
`timescale 1ns/100ps
`default_nettype none

module tb_pll_reconf
  import pll_reconf_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int NUM_ROWS   = 18;
  localparam int MAX_WAIT   = 200;
  localparam logic [31:0] ROM_REFCLK = 32'hA1CC_59E3; // Ids 3, 15, 22, 24, 28 plus junk above
  localparam logic [31:0] ROM_CGB    = 32'h5B0C_3976; // Ids 6, 7, 9, 3, 12 plus junk above

  typedef enum logic [1:0] {K_READ, K_LOOKUP, K_SWITCH} row_kind_e;

  typedef struct packed {
    row_kind_e   kind;
    logic [2:0]  addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [15:0] exp_pri; // Field bits the merge puts in the primary word
    logic [15:0] exp_sec;
  } row_t;

  logic                   clk = 1'b0;
  logic                   reset = 1'b1;
  logic                   uif_go = 1'b0;
  uif_mode_e              uif_mode = UIF_RD;
  logic [UIF_ADDR_W-1:0]  uif_addr = '0;
  logic [UIF_DATA_W-1:0]  uif_wdata = '0;
  logic [LCH_W-1:0]       uif_lch = 10'h1A5;
  logic                   ctrl_wait = 1'b0;
  logic [CTRL_DATA_W-1:0] ctrl_rdata = '0;
  logic                   uif_busy;
  logic [UIF_DATA_W-1:0]  uif_rdata;
  logic                   uif_addr_err;
  logic                   ctrl_go;
  ctrl_op_e               ctrl_opcode;
  logic                   ctrl_lock;
  logic [LCH_W-1:0]       ctrl_lch;
  logic [CTRL_ADDR_W-1:0] ctrl_addr;
  logic [CTRL_DATA_W-1:0] ctrl_wdata;

  row_t        rows [0:NUM_ROWS-1];
  logic [15:0] dprio_mem [0:4095];
  logic [1:0]  wait_cnt = 2'd0;
  ctrl_op_e    go_ops [$];
  logic [11:0] go_addrs [$];
  logic        go_locks [$];
  int          errors = 0;
  int          failed_tests = 0;

  pll_reconf_top i_dut (
    .clk, .reset, .uif_go, .uif_mode, .uif_busy, .uif_addr, .uif_wdata, .uif_rdata,
    .uif_addr_err, .uif_lch, .ctrl_go, .ctrl_opcode, .ctrl_lock, .ctrl_wait, .ctrl_lch,
    .ctrl_addr, .ctrl_rdata, .ctrl_wdata
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Basic-block model, answers each request after two busy cycles
  always @(posedge clk) begin
    if (reset) begin
      ctrl_wait <= 1'b0;
      wait_cnt  <= 2'd0;
    end else if (ctrl_go) begin
      ctrl_wait <= 1'b1;
      wait_cnt  <= 2'd1;
      case (ctrl_opcode)
        OP_ROM_RD: ctrl_rdata <= (ctrl_addr == 12'd1) ? ROM_REFCLK :
                                 (ctrl_addr == 12'd2) ? ROM_CGB : 32'h0;
        OP_RD:     ctrl_rdata <= {16'hBEEF, dprio_mem[ctrl_addr]}; // Upper half is ignored
        OP_WR:     dprio_mem[ctrl_addr] <= ctrl_wdata[15:0];
        default:   ;
      endcase
    end else if (wait_cnt != 2'd0) begin
      wait_cnt <= wait_cnt - 2'd1;
    end else begin
      ctrl_wait <= 1'b0;
    end
  end

  // Records every request on the control port
  always @(posedge clk) begin
    if (!reset && ctrl_go) begin
      go_ops.push_back(ctrl_opcode);
      go_addrs.push_back(ctrl_addr);
      go_locks.push_back(ctrl_lock);
      if (ctrl_lch !== uif_lch) begin
        $display("FAIL ctrl_lch got 0x%h expected 0x%h", ctrl_lch, uif_lch);
        errors++;
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_ROWS * MAX_WAIT + 10));
    $display("Watchdog expired before all %0d tests finished", NUM_ROWS);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_busy(input logic level, output logic ok);
    int cnt;
    cnt = 0;
    while (uif_busy !== level && cnt < MAX_WAIT) begin
      @(negedge clk);
      cnt++;
    end
    ok = (uif_busy === level);
  endtask

  function automatic string kind_label(input row_kind_e kind);
    case (kind)
      K_LOOKUP: return "lookup";
      K_SWITCH: return "switch";
      default:  return "read";
    endcase
  endfunction

  task automatic check_pulses(input row_kind_e kind, input logic [11:0] rom_sel,
                              input logic [11:0] pri_ofst, input logic [11:0] sec_ofst);
    ctrl_op_e    exp_ops [$];
    logic [11:0] exp_addrs [$];
    logic        exp_locks [$];
    if (kind == K_LOOKUP) begin
      exp_ops   = '{OP_ROM_RD};
      exp_addrs = '{rom_sel};
      exp_locks = '{1'b0};
    end else if (kind == K_SWITCH) begin
      exp_ops   = '{OP_ROM_RD, OP_RD, OP_WR, OP_RD, OP_WR}; // Secondary word first
      exp_addrs = '{rom_sel, sec_ofst, sec_ofst, pri_ofst, pri_ofst};
      exp_locks = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
    end
    if (go_ops.size() != exp_ops.size()) begin
      $display("Saw %0d ctrl_go pulses where %0d were expected", go_ops.size(), exp_ops.size());
      errors++;
    end else begin
      for (int k = 0; k < exp_ops.size(); k++) begin
        check_hex("ctrl_opcode", 32'(go_ops[k]), 32'(exp_ops[k]));
        check_hex("ctrl_addr", 32'(go_addrs[k]), 32'(exp_addrs[k]));
        check_hex("ctrl_lock", 32'(go_locks[k]), 32'(exp_locks[k]));
      end
    end
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    int          errs_before;
    logic        is_cgb;
    logic        ok;
    logic [11:0] pri_ofst;
    logic [11:0] sec_ofst;
    logic [15:0] pri_mask;
    logic [15:0] sec_mask;
    logic [15:0] pri_prior;
    logic [15:0] sec_prior;
    r           = rows[idx];
    errs_before = errors;
    is_cgb      = (r.addr == 3'd1) || (r.addr == 3'd3);
    pri_ofst    = is_cgb ? OFST_CGB : OFST_REFIQ;
    sec_ofst    = is_cgb ? OFST_CLKNET : OFST_PCIEMD_RREF;
    pri_mask    = is_cgb ? 16'h183F : 16'h07F8;
    sec_mask    = is_cgb ? 16'h0200 : 16'hC000;
    if (r.kind == K_SWITCH) begin
      dprio_mem[pri_ofst] = 16'($urandom); // Fresh prior contents per switch
      dprio_mem[sec_ofst] = 16'($urandom);
    end
    pri_prior = dprio_mem[pri_ofst];
    sec_prior = dprio_mem[sec_ofst];
    go_ops.delete();
    go_addrs.delete();
    go_locks.delete();

    @(posedge clk);
    uif_go    <= 1'b1;
    uif_mode  <= (r.kind == K_SWITCH) ? UIF_WR : UIF_RD;
    uif_addr  <= r.addr;
    uif_wdata <= r.wdata;
    @(posedge clk);
    uif_go <= 1'b0;
    @(negedge clk);
    if (r.kind != K_READ) begin
      wait_busy(1'b1, ok);
      if (!ok) begin
        $display("uif_busy never rose in test %0d", idx);
        errors++;
      end else begin
        wait_busy(1'b0, ok);
        if (!ok) begin
          $display("uif_busy stayed high in test %0d", idx);
          errors++;
        end
      end
      @(posedge clk); // Lookup readback refreshes here
      @(negedge clk);
    end

    if (r.kind == K_SWITCH) begin
      check_hex("dprio primary", 32'(dprio_mem[pri_ofst]),
                32'((pri_prior & ~pri_mask) | r.exp_pri));
      check_hex("dprio secondary", 32'(dprio_mem[sec_ofst]),
                32'((sec_prior & ~sec_mask) | r.exp_sec));
    end else begin
      check_hex("uif_rdata", uif_rdata, r.exp_rdata);
      check_hex("uif_addr_err", 32'(uif_addr_err), 32'(r.exp_err));
    end
    check_pulses(r.kind, is_cgb ? 12'd2 : 12'd1, pri_ofst, sec_ofst);

    if (errors == errs_before) begin
      $display("test %0d %s offset %0d ok", idx, kind_label(r.kind), r.addr);
    end else begin
      $display("test %0d %s offset %0d had %0d errors", idx, kind_label(r.kind), r.addr,
               errors - errs_before);
      failed_tests++;
    end
  endtask

  initial begin
    int seed;
    seed = $urandom(32'ha9fd_9a00);
    for (int a = 0; a < 4096; a++)
      dprio_mem[a] = 16'($urandom);

    // kind, offset, wdata, readback, addr_err, primary bits, secondary bits
    rows[0]  = '{K_READ,   3'd0, 32'h0,          32'h0,         1'b0, 16'h0,    16'h0};
    rows[1]  = '{K_LOOKUP, 3'd2, 32'h0,          32'h01CC_59E3, 1'b0, 16'h0,    16'h0};
    rows[2]  = '{K_LOOKUP, 3'd3, 32'h0,          32'h000C_3976, 1'b0, 16'h0,    16'h0};
    rows[3]  = '{K_SWITCH, 3'd0, 32'h0,          32'h0,         1'b0, 16'h0020, 16'h0};
    rows[4]  = '{K_SWITCH, 3'd0, 32'hFFFF_FFF9,  32'h0,         1'b0, 16'h0280, 16'h0};
    rows[5]  = '{K_SWITCH, 3'd0, 32'h2,          32'h0,         1'b0, 16'h0,    16'h8000};
    rows[6]  = '{K_SWITCH, 3'd0, 32'h3,          32'h0,         1'b0, 16'h0060, 16'h0};
    rows[7]  = '{K_SWITCH, 3'd0, 32'h4,          32'h0,         1'b0, 16'h0008, 16'h0};
    rows[8]  = '{K_SWITCH, 3'd0, 32'h6,          32'h0,         1'b0, 16'h0020, 16'h0};
    rows[9]  = '{K_SWITCH, 3'd1, 32'h0,          32'h0,         1'b0, 16'h1028, 16'h0200};
    rows[10] = '{K_SWITCH, 3'd1, 32'h1,          32'h0,         1'b0, 16'h0824, 16'h0200};
    rows[11] = '{K_SWITCH, 3'd1, 32'h2,          32'h0,         1'b0, 16'h0028, 16'h0200};
    rows[12] = '{K_SWITCH, 3'd1, 32'h3,          32'h0,         1'b0, 16'h0012, 16'h0};
    rows[13] = '{K_SWITCH, 3'd1, 32'h4,          32'h0,         1'b0, 16'h002C, 16'h0};
    rows[14] = '{K_READ,   3'd0, 32'h0,          32'h6,         1'b0, 16'h0,    16'h0};
    rows[15] = '{K_READ,   3'd1, 32'h0,          32'h4,         1'b0, 16'h0,    16'h0};
    rows[16] = '{K_READ,   3'd5, 32'h0,          32'h0,         1'b1, 16'h0,    16'h0};
    rows[17] = '{K_READ,   3'd7, 32'h0,          32'h0,         1'b1, 16'h0,    16'h0};

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_hex("uif_busy", 32'(uif_busy), 32'h0);
    check_hex("ctrl_go", 32'(ctrl_go), 32'h0);
    check_hex("ctrl_lock", 32'(ctrl_lock), 32'h0);
    check_hex("ctrl_opcode", 32'(ctrl_opcode), 32'h0);
    check_hex("ctrl_addr", 32'(ctrl_addr), 32'h0);
    check_hex("ctrl_wdata", ctrl_wdata, 32'h0);

    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);

    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures", NUM_ROWS,
             failed_tests, errors, i_dut.i_seq.i_props.fail_count);
    if (errors == 0 && i_dut.i_seq.i_props.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_pll_reconf_props.sv
// Control port and busy assertions for pll_reconf_seq
// Checked only while reset is low
`timescale 1ns/100ps
`default_nettype none

module tb_pll_reconf_props
  import pll_reconf_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       ctrl_go,
  input logic       ctrl_wait,
  input logic       ctrl_lock,
  input logic       uif_busy,
  input pll_state_e state
);

  int unsigned fail_count = 0;

  go_one_cycle: assert property (@(posedge clk) disable iff (reset) ctrl_go |=> !ctrl_go)
    else begin
      $error("ctrl_go held for more than one cycle");
      fail_count++;
    end

  // Basic block is busy, nothing may be issued
  no_go_in_wait: assert property (@(posedge clk) disable iff (reset) ctrl_wait |-> !ctrl_go)
    else begin
      $error("ctrl_go issued while ctrl_wait is high");
      fail_count++;
    end

  // Idle means the user port is free and the channel lock is released
  idle_not_busy: assert property (@(posedge clk) disable iff (reset)
                                  (state == ST_IDLE) |-> (!uif_busy && !ctrl_lock))
    else begin
      $error("uif_busy or ctrl_lock high in idle state");
      fail_count++;
    end

endmodule

bind pll_reconf_seq tb_pll_reconf_props i_props (
  .clk, .reset, .ctrl_go, .ctrl_wait, .ctrl_lock, .uif_busy, .state
);

`default_nettype wire
